// File: logic/vslide_defines.svh
// widths shared by the slide unit RTL and its testbench
// include wherever one of the macros is used
`ifndef VSLIDE_DEFINES_SVH
`define VSLIDE_DEFINES_SVH

// bits per vector register
`define VSLIDE_VREG_W 128

// one write chunk
`define VSLIDE_OP_W 32
`define VSLIDE_CHUNK_CNT 4

`define VSLIDE_VADDR_W 5
`define VSLIDE_ID_W 3

`endif

// File: logic/vslide_pkg.sv
// types shared by the slide unit modules and the testbench
`default_nettype none

`include "vslide_defines.svh"

package vslide_pkg;

    typedef enum logic [1:0] {
        SLD_UP    = 2'd0,
        SLD_DOWN  = 2'd1,
        SLD_1UP   = 2'd2,
        SLD_1DOWN = 2'd3
    } sld_op_e;

    typedef enum logic [1:0] {
        VSEW_8  = 2'd0,
        VSEW_16 = 2'd1,
        VSEW_32 = 2'd2
    } vsew_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WAIT  = 2'd2,
        WRITE = 2'd3
    } ctrl_state_e;

    typedef struct packed {
        sld_op_e                    op;
        vsew_e                      vsew;
        logic [4:0]                 offset;     // in elements
        logic [31:0]                xval;
        logic [`VSLIDE_VADDR_W-1:0] vs2;
        logic [`VSLIDE_VADDR_W-1:0] vd;
        logic [4:0]                 vl;
        logic [`VSLIDE_ID_W-1:0]    id;
    } sld_cmd_t;

    typedef struct packed {
        logic [6:0]                 byte_off;
        logic [4:0]                 vl_bytes;   // clamped to one register
        logic                       is_down;
        logic                       ins_first;  // scalar goes to element 0
        logic                       ins_last;   // scalar goes to last active element
        logic [2:0]                 ins_bytes;
        logic [31:0]                xval;
        logic [`VSLIDE_VADDR_W-1:0] vs2;
        logic [`VSLIDE_VADDR_W-1:0] vd;
        logic [`VSLIDE_ID_W-1:0]    id;
    } sld_setup_t;

endpackage

`default_nettype wire

// File: logic/vslide_chunk_if.sv
// chunk sequencing between the controller, the chunk counter and the shifter
`timescale 1ns/1ps
`default_nettype none

`include "vslide_defines.svh"

interface vslide_chunk_if;

    logic                                  src_load;   // capture read data
    logic                                  chunk_go;   // one chunk out this cycle
    logic [$clog2(`VSLIDE_CHUNK_CNT)-1:0]  chunk_idx;
    logic                                  last_chunk;

    modport ctrl (output src_load, output chunk_go, input last_chunk);
    modport cnt  (input src_load, input chunk_go, output chunk_idx, output last_chunk);
    modport data (input src_load, input chunk_go, input chunk_idx, input last_chunk);

endinterface

`default_nettype wire

// File: logic/vslide_setup.sv
// converts an accepted slide command into byte offset, byte length and
// scalar insert flags, held for the whole instruction
`timescale 1ns/1ps
`default_nettype none

`include "vslide_defines.svh"

module vslide_setup (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   accept_i,
    input  vslide_pkg::sld_cmd_t   cmd_i,
    output vslide_pkg::sld_setup_t setup_o
);

    import vslide_pkg::*;

    localparam int unsigned VREG_BYTES = `VSLIDE_VREG_W / 8;

    logic [1:0] esh;        // log2 of element bytes
    logic [6:0] elem_bytes;
    logic [6:0] off_bytes;
    logic [6:0] vl_full;
    sld_setup_t setup_d;

    always_comb begin
        unique case (cmd_i.vsew)
            VSEW_16: esh = 2'd1;
            VSEW_32: esh = 2'd2;
            default: esh = 2'd0;
        endcase
    end

    assign elem_bytes = 7'd1 << esh;
    assign off_bytes  = {2'b00, cmd_i.offset} << esh;
    assign vl_full    = {2'b00, cmd_i.vl} << esh;

    always_comb begin
        setup_d.is_down   = (cmd_i.op == SLD_DOWN) || (cmd_i.op == SLD_1DOWN);
        setup_d.ins_first = cmd_i.op == SLD_1UP;
        setup_d.ins_last  = cmd_i.op == SLD_1DOWN;
        // slide1 forms always move by one element
        if (setup_d.ins_first || setup_d.ins_last) begin
            setup_d.byte_off = elem_bytes;
        end else begin
            setup_d.byte_off = off_bytes;
        end
        if (vl_full > 7'(VREG_BYTES)) begin
            setup_d.vl_bytes = 5'(VREG_BYTES);
        end else begin
            setup_d.vl_bytes = vl_full[4:0];
        end
        setup_d.ins_bytes = elem_bytes[2:0];
        setup_d.xval      = cmd_i.xval;
        setup_d.vs2       = cmd_i.vs2;
        setup_d.vd        = cmd_i.vd;
        setup_d.id        = cmd_i.id;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            setup_o <= '0;
        end else if (accept_i) begin
            setup_o <= setup_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/vslide_ctrl.sv
// accepts one slide at a time, issues the source read, then four chunk
// writes, flagging done with the instruction id on the last one
`timescale 1ns/1ps
`default_nettype none

`include "vslide_defines.svh"

module vslide_ctrl (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       cmd_valid_i,
    input  vslide_pkg::sld_setup_t     setup_i,
    output logic                       accept_o,
    output logic                       busy_o,
    output logic                       vreg_rd_en_o,
    output logic [`VSLIDE_VADDR_W-1:0] vreg_rd_addr_o,
    output logic                       vreg_wr_en_o,
    output logic [`VSLIDE_VADDR_W-1:0] vreg_wr_addr_o,
    output logic                       done_valid_o,
    output logic [`VSLIDE_ID_W-1:0]    done_id_o,
    vslide_chunk_if.ctrl               chunk
);

    import vslide_pkg::*;

    ctrl_state_e state_q, state_d;
    logic        rd_en_q;
    logic        wr_en_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    if (cmd_valid_i) state_d = READ;
            READ:    state_d = WAIT;
            WAIT:    state_d = WRITE;   // read data arrives
            WRITE:   if (chunk.last_chunk) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            state_q <= state_d;
            rd_en_q <= state_d == READ;
            wr_en_q <= state_d == WRITE;
        end
    end

    ////////////////////
    // outputs

    assign accept_o       = (state_q == IDLE) && cmd_valid_i;
    assign busy_o         = state_q != IDLE;
    assign vreg_rd_en_o   = rd_en_q;
    assign vreg_rd_addr_o = setup_i.vs2;
    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = setup_i.vd;
    assign done_valid_o   = wr_en_q && chunk.last_chunk;
    assign done_id_o      = setup_i.id;

    assign chunk.src_load = state_q == WAIT;
    assign chunk.chunk_go = wr_en_q;

endmodule

`default_nettype wire

// File: logic/vslide_chunk_counter.sv
// chunk index for the write phase, restarts with every source load
`timescale 1ns/1ps
`default_nettype none

`include "vslide_defines.svh"

module vslide_chunk_counter (
    input  logic        clk_i,
    input  logic        reset_i,
    vslide_chunk_if.cnt chunk
);

    localparam int unsigned IDX_W = $clog2(`VSLIDE_CHUNK_CNT);

    logic [IDX_W-1:0] idx_q;

    always_ff @(posedge clk_i) begin
        if (reset_i || chunk.src_load) begin
            idx_q <= '0;
        end else if (chunk.chunk_go) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign chunk.chunk_idx  = idx_q;
    assign chunk.last_chunk = idx_q == IDX_W'(`VSLIDE_CHUNK_CNT - 1);

endmodule

`default_nettype wire

// File: logic/vslide_shifter.sv
// holds the source register and forms each result chunk with its byte mask
// from the slide setup and the current chunk index
`timescale 1ns/1ps
`default_nettype none

`include "vslide_defines.svh"

module vslide_shifter (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  vslide_pkg::sld_setup_t       setup_i,
    input  logic [`VSLIDE_VREG_W-1:0]    vreg_rd_data_i,
    vslide_chunk_if.data                 chunk,
    output logic [`VSLIDE_OP_W-1:0]      wr_data_o,
    output logic [`VSLIDE_OP_W/8-1:0]    wr_mask_o,
    output logic [1:0]                   wr_chunk_o
);

    localparam int unsigned OP_BYTES   = `VSLIDE_OP_W / 8;
    localparam int unsigned VREG_BYTES = `VSLIDE_VREG_W / 8;
    localparam int unsigned BIDX_W     = $clog2(VREG_BYTES);

    logic [VREG_BYTES-1:0][7:0] src_q;
    logic                       src_vld_q;  // source held and chunks outstanding
    logic [7:0]                 boff, lbytes, sbytes, ins_base;

    always_ff @(posedge clk_i) begin
        if (chunk.src_load) begin
            src_q <= vreg_rd_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            src_vld_q <= 1'b0;
        end else if (chunk.src_load) begin
            src_vld_q <= 1'b1;
        end else if (chunk.chunk_go && chunk.last_chunk) begin
            src_vld_q <= 1'b0;
        end
    end

    assign boff     = 8'(setup_i.byte_off);
    assign lbytes   = 8'(setup_i.vl_bytes);
    assign sbytes   = 8'(setup_i.ins_bytes);
    assign ins_base = lbytes - sbytes;   // first byte of the last element

    ////////////////////
    // per byte select

    always_comb begin
        logic [7:0] pos;
        logic [7:0] src_pos;
        logic [7:0] byte_val;
        logic       en;

        for (int j = 0; j < OP_BYTES; j++) begin
            pos = 8'(chunk.chunk_idx) * 8'(OP_BYTES) + 8'(j);
            if (setup_i.is_down) begin
                src_pos  = pos + boff;
                byte_val = (src_pos < 8'(VREG_BYTES)) ? src_q[src_pos[BIDX_W-1:0]] : 8'h00;
                en       = pos < lbytes;
            end else begin
                src_pos  = pos - boff;
                byte_val = (pos >= boff) ? src_q[src_pos[BIDX_W-1:0]] : 8'h00;
                // element 0 of a slide1up takes the scalar
                en       = (setup_i.ins_first || pos >= boff) && pos < lbytes;
            end

            if (setup_i.ins_first && pos < sbytes) begin
                byte_val = setup_i.xval[8*pos[1:0] +: 8];
            end
            if (setup_i.ins_last && lbytes != 8'd0 && pos >= ins_base && pos < lbytes) begin
                byte_val = setup_i.xval[8*(pos[1:0] - ins_base[1:0]) +: 8];
            end

            wr_data_o[8*j +: 8] = byte_val;
            wr_mask_o[j]        = en && src_vld_q;
        end
    end

    assign wr_chunk_o = chunk.chunk_idx;

endmodule

`default_nettype wire

// File: logic/vslide_top.sv
// vector slide unit top level
// one command per strobe, watch busy_o before sending the next one
`timescale 1ns/1ps
`default_nettype none

`include "vslide_defines.svh"

module vslide_top (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        cmd_valid_i,
    input  vslide_pkg::sld_op_e         cmd_op_i,
    input  vslide_pkg::vsew_e           cmd_vsew_i,
    input  logic [4:0]                  cmd_offset_i,
    input  logic [31:0]                 cmd_xval_i,
    input  logic [`VSLIDE_VADDR_W-1:0]  cmd_vs2_i,
    input  logic [`VSLIDE_VADDR_W-1:0]  cmd_vd_i,
    input  logic [4:0]                  cmd_vl_i,
    input  logic [`VSLIDE_ID_W-1:0]     cmd_id_i,
    output logic                        busy_o,
    output logic                        vreg_rd_en_o,
    output logic [`VSLIDE_VADDR_W-1:0]  vreg_rd_addr_o,
    input  logic [`VSLIDE_VREG_W-1:0]   vreg_rd_data_i,
    output logic                        vreg_wr_en_o,
    output logic [`VSLIDE_VADDR_W-1:0]  vreg_wr_addr_o,
    output logic [1:0]                  vreg_wr_chunk_o,
    output logic [`VSLIDE_OP_W-1:0]     vreg_wr_data_o,
    output logic [`VSLIDE_OP_W/8-1:0]   vreg_wr_mask_o,
    output logic                        done_valid_o,
    output logic [`VSLIDE_ID_W-1:0]     done_id_o
);

    import vslide_pkg::*;

    sld_cmd_t   cmd;
    sld_setup_t setup;
    logic       accept;

    assign cmd = '{
        op:     cmd_op_i,
        vsew:   cmd_vsew_i,
        offset: cmd_offset_i,
        xval:   cmd_xval_i,
        vs2:    cmd_vs2_i,
        vd:     cmd_vd_i,
        vl:     cmd_vl_i,
        id:     cmd_id_i
    };

    vslide_chunk_if chunk_if0 ();

    vslide_setup setup0 (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .accept_i (accept),
        .cmd_i    (cmd),
        .setup_o  (setup)
    );

    vslide_ctrl ctrl0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .cmd_valid_i    (cmd_valid_i),
        .setup_i        (setup),
        .accept_o       (accept),
        .busy_o         (busy_o),
        .vreg_rd_en_o   (vreg_rd_en_o),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .done_valid_o   (done_valid_o),
        .done_id_o      (done_id_o),
        .chunk          (chunk_if0.ctrl)
    );

    vslide_chunk_counter cnt0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .chunk   (chunk_if0.cnt)
    );

    vslide_shifter shift0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .setup_i        (setup),
        .vreg_rd_data_i (vreg_rd_data_i),
        .chunk          (chunk_if0.data),
        .wr_data_o      (vreg_wr_data_o),
        .wr_mask_o      (vreg_wr_mask_o),
        .wr_chunk_o     (vreg_wr_chunk_o)
    );

endmodule

`default_nettype wire

// File: tb/vslide_chk.sv
// concurrent assertions on the slide controller strobes, bound into vslide_ctrl
`timescale 1ns/1ps
`default_nettype none

module vslide_chk (
    input logic clk_i,
    input logic reset_i,
    input logic accept_i,
    input logic busy_i,
    input logic rd_en_i,
    input logic wr_en_i,
    input logic done_i
);

    int unsigned fail_cnt = 0;  // read back by the testbench

    rd_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
        rd_en_i |-> $past(accept_i))
        else begin $error("read without an accept"); fail_cnt++; end

    four_writes: assert property (@(posedge clk_i) disable iff (reset_i)
        rd_en_i |=> !wr_en_i ##1 wr_en_i [*4] ##1 !wr_en_i)
        else begin $error("write burst is not four chunks"); fail_cnt++; end

    // last chunk is the fourth write in a row
    done_on_last: assert property (@(posedge clk_i) disable iff (reset_i)
        done_i == (wr_en_i && $past(wr_en_i, 3)))
        else begin $error("done not on chunk 3"); fail_cnt++; end

    // read, wait and all four writes lie inside this window
    busy_held: assert property (@(posedge clk_i) disable iff (reset_i)
        accept_i |=> busy_i [*6])
        else begin $error("busy dropped early"); fail_cnt++; end

endmodule

bind vslide_ctrl vslide_chk chk0 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .accept_i (accept_o),
    .busy_i   (busy_o),
    .rd_en_i  (vreg_rd_en_o),
    .wr_en_i  (vreg_wr_en_o),
    .done_i   (done_valid_o)
);

`default_nettype wire

// File: tb/vslide_tb.sv
// testbench for the slide unit: random slides checked against a byte model
// a register-file model answers reads one cycle after the read strobe
`timescale 1ns/1ps
`default_nettype none

`include "vslide_defines.svh"

module vslide_tb;

    import vslide_pkg::*;

    localparam logic [31:0] SEED        = 32'haa91ecdc;
    localparam int          CLK_PERIOD  = 40;
    localparam int          N_INSNS     = 200;
    localparam int          TIMEOUT_CYC = 16;

    logic                       clk;
    logic                       reset;
    logic                       cmd_valid;
    sld_op_e                    cmd_op;
    vsew_e                      cmd_vsew;
    logic [4:0]                 cmd_offset, cmd_vl;
    logic [31:0]                cmd_xval;
    logic [`VSLIDE_VADDR_W-1:0] cmd_vs2, cmd_vd, rd_addr, wr_addr;
    logic [`VSLIDE_ID_W-1:0]    cmd_id, done_id;
    logic                       busy, rd_en, wr_en, done_valid;
    logic [`VSLIDE_VREG_W-1:0]  rd_data = '0;
    logic [1:0]                 wr_chunk;
    logic [`VSLIDE_OP_W-1:0]    wr_data;
    logic [`VSLIDE_OP_W/8-1:0]  wr_mask;

    logic [`VSLIDE_VREG_W-1:0]  vrf [2**`VSLIDE_VADDR_W];
    logic                       rd_pending = 1'b0;
    logic [`VSLIDE_VADDR_W-1:0] rd_addr_q  = '0;

    vslide_top dut0 (
        .clk_i (clk), .reset_i (reset), .cmd_valid_i (cmd_valid),
        .cmd_op_i (cmd_op), .cmd_vsew_i (cmd_vsew), .cmd_offset_i (cmd_offset),
        .cmd_xval_i (cmd_xval), .cmd_vs2_i (cmd_vs2), .cmd_vd_i (cmd_vd),
        .cmd_vl_i (cmd_vl), .cmd_id_i (cmd_id), .busy_o (busy),
        .vreg_rd_en_o (rd_en), .vreg_rd_addr_o (rd_addr), .vreg_rd_data_i (rd_data),
        .vreg_wr_en_o (wr_en), .vreg_wr_addr_o (wr_addr), .vreg_wr_chunk_o (wr_chunk),
        .vreg_wr_data_o (wr_data), .vreg_wr_mask_o (wr_mask),
        .done_valid_o (done_valid), .done_id_o (done_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // read data shows up in the cycle after the strobe
    always @(negedge clk) begin
        if (rd_pending) rd_data = vrf[rd_addr_q];
        rd_pending = (rd_en === 1'b1);
        rd_addr_q  = rd_addr;
    end

    ////////////////////
    // error reporting

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("ERR %s: expected %0h, actual %0h", name, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic compare_data(input string name, input logic [`VSLIDE_OP_W-1:0] exp,
                                input logic [`VSLIDE_OP_W-1:0] act,
                                input logic [`VSLIDE_OP_W/8-1:0] mask);
        logic [`VSLIDE_OP_W-1:0] bits;
        for (int k = 0; k < `VSLIDE_OP_W/8; k++) begin
            bits[8*k +: 8] = {8{mask[k]}};
        end
        if ((exp & bits) !== (act & bits)) report_mismatch(name, exp & bits, act & bits);
    endtask

    task automatic compare_mask(input string name, input logic [`VSLIDE_OP_W/8-1:0] exp,
                                input logic [`VSLIDE_OP_W/8-1:0] act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic compare_id(input string name, input logic [`VSLIDE_ID_W-1:0] exp,
                              input logic [`VSLIDE_ID_W-1:0] act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic expect_strobe(input string name, input logic exp, input logic act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic expect_addr(input string name, input logic [`VSLIDE_VADDR_W-1:0] exp,
                               input logic [`VSLIDE_VADDR_W-1:0] act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    ////////////////////
    // stimulus and model

    task automatic randomize_cmd();
        cmd_op     = sld_op_e'($urandom_range(0, 3));
        cmd_vsew   = vsew_e'($urandom_range(0, 2));
        cmd_offset = 5'($urandom);
        cmd_vl     = 5'($urandom);
        cmd_xval   = $urandom;
        cmd_vs2    = `VSLIDE_VADDR_W'($urandom);
        cmd_vd     = `VSLIDE_VADDR_W'($urandom);
        cmd_id     = `VSLIDE_ID_W'($urandom);
    endtask

    task automatic slide_model(input sld_op_e op, input vsew_e vsew, input logic [4:0] offset,
                               input logic [4:0] vl, input logic [31:0] xval,
                               input logic [127:0] src, output logic [127:0] exp_data,
                               output logic [15:0] exp_mask);
        int         s, l, b;
        logic [7:0] val;
        s = 1 << int'(vsew);
        l = int'(vl) * s;
        if (l > 16) l = 16;    // one register at most
        b = (op == SLD_UP || op == SLD_DOWN) ? int'(offset) * s : s;
        for (int i = 0; i < 16; i++) begin
            val = 8'h00;
            if (op == SLD_UP || op == SLD_1UP) begin
                if (i >= b) val = src[8*(i-b) +: 8];
                exp_mask[i] = (op == SLD_1UP || i >= b) && i < l;  // scalar bytes active
            end else begin
                if (i + b < 16) val = src[8*(i+b) +: 8];
                exp_mask[i] = i < l;
            end
            if (op == SLD_1UP && i < s) val = xval[8*i +: 8];
            if (op == SLD_1DOWN && l > 0 && i >= l - s && i < l) val = xval[8*(i-l+s) +: 8];
            exp_data[8*i +: 8] = val;
        end
    endtask

    task automatic check_idle(input string name);
        expect_strobe({name, " busy"}, 1'b0, busy);
        expect_strobe({name, " read"}, 1'b0, rd_en);
        expect_strobe({name, " write"}, 1'b0, wr_en);
        expect_strobe({name, " done"}, 1'b0, done_valid);
    endtask

    initial begin
        int           cyc, c;
        logic         done_seen;
        sld_op_e      op;
        logic [4:0]   vd;
        logic [4:0]   vs2;
        logic [2:0]   id;
        logic [127:0] exp_data;
        logic [15:0]  exp_mask;
        string        tname;

        void'($urandom(SEED));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        randomize_cmd();
        for (int a = 0; a < 2**`VSLIDE_VADDR_W; a++) begin
            vrf[a] = {$urandom, $urandom, $urandom, $urandom};
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;

        for (int n = 0; n < N_INSNS; n++) begin
            @(negedge clk);
            tname = $sformatf("insn %0d", n);
            check_idle({tname, " idle"});
            randomize_cmd();
            cmd_valid = 1'b1;
            op  = cmd_op;
            vd  = cmd_vd;
            vs2 = cmd_vs2;
            id  = cmd_id;
            tname = $sformatf("insn %0d %s", n, op.name());
            slide_model(cmd_op, cmd_vsew, cmd_offset, cmd_vl, cmd_xval, vrf[cmd_vs2],
                        exp_data, exp_mask);

            cyc       = 0;
            done_seen = 1'b0;
            while (!done_seen) begin
                @(negedge clk);
                cyc++;
                if (cyc > TIMEOUT_CYC) stop_on_timeout("done from the slide unit");
                cmd_valid = 1'b0;
                if (busy && $urandom_range(0, 3) == 0) begin
                    randomize_cmd();    // must be ignored
                    cmd_valid = 1'b1;
                end
                expect_strobe({tname, " read strobe"}, cyc == 1, rd_en);
                if (rd_en) begin
                    expect_addr({tname, " read addr"}, vs2, rd_addr);
                end
                expect_strobe({tname, " busy"}, cyc <= 6, busy);
                expect_strobe({tname, " write strobe"}, cyc >= 3 && cyc <= 6, wr_en);
                expect_strobe({tname, " done"}, cyc == 6, done_valid);
                if (wr_en) begin
                    c = cyc - 3;
                    expect_addr({tname, " write addr"}, vd, wr_addr);
                    expect_addr({tname, " chunk index"}, 5'(c), 5'(wr_chunk));
                    compare_mask($sformatf("%s chunk %0d mask", tname, c),
                                 exp_mask[4*c +: 4], wr_mask);
                    compare_data($sformatf("%s chunk %0d data", tname, c),
                                 exp_data[32*c +: 32], wr_data, exp_mask[4*c +: 4]);
                    for (int k = 0; k < 4; k++) begin
                        if (exp_mask[4*c+k]) vrf[vd][8*(4*c+k) +: 8] = exp_data[8*(4*c+k) +: 8];
                    end
                end
                if (done_valid) begin
                    compare_id({tname, " done id"}, id, done_id);
                    done_seen = 1'b1;
                end
            end
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        check_idle("final idle");

        if (dut0.ctrl0.chk0.fail_cnt != 0) begin
            $display("control checker reported %0d assertion failures",
                     dut0.ctrl0.chk0.fail_cnt);
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/vslide_pkg.sv
logic/vslide_chunk_if.sv
logic/vslide_setup.sv
logic/vslide_ctrl.sv
logic/vslide_chunk_counter.sv
logic/vslide_shifter.sv
logic/vslide_top.sv
tb/vslide_chk.sv
tb/vslide_tb.sv

// File: Bender.yml
package:
  name: vslide

sources:
  - include_dirs:
      - logic
    files:
      - logic/vslide_pkg.sv
      - logic/vslide_chunk_if.sv
      - logic/vslide_setup.sv
      - logic/vslide_ctrl.sv
      - logic/vslide_chunk_counter.sv
      - logic/vslide_shifter.sv
      - logic/vslide_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/vslide_chk.sv
      - tb/vslide_tb.sv
